// File: all.f
+incdir+.
sha256_pkg.sv
sha256_msg_loader.sv
sha256_schedule.sv
sha256_compress.sv
sha256_digest_out.sv
sha256_top.sv
tb_sha256.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SHA-256 testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -f all.f --top-module tb_sha256 -o sim_tb_sha256; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_sha256)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi

exit 1

// File: sha256_compress.sv
`timescale 1ns/1ps
`default_nettype none

module sha256_compress
    import sha256_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    block_start,
    input  word_t   w_cur,
    output logic    round_step,
    output logic    digest_done,
    output digest_t digest
);

    logic running;
    logic [6:0] round_cnt;
    logic last_round;
    word_t a, b, c, d, e, f, g, h;
    word_t t1, t2;

    assign last_round = (round_cnt == 7'(NUM_ROUNDS));
    assign round_step = running && !last_round;

    assign t1 = h + big_sigma1(e) + ch(e, f, g) + round_k(round_cnt[5:0]) + w_cur;
    assign t2 = big_sigma0(a) + maj(a, b, c);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running     <= 1'b0;
            round_cnt   <= '0;
            digest_done <= 1'b0;
        end else begin
            digest_done <= 1'b0;
            if (block_start) begin
                running   <= 1'b1;
                round_cnt <= '0;
            end else if (round_step) begin
                round_cnt <= round_cnt + 7'd1;
            end else if (running) begin
                // Extra cycle after round 63 for the hash addition
                running     <= 1'b0;
                digest_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (block_start) begin
            a <= H_INIT[0];
            b <= H_INIT[1];
            c <= H_INIT[2];
            d <= H_INIT[3];
            e <= H_INIT[4];
            f <= H_INIT[5];
            g <= H_INIT[6];
            h <= H_INIT[7];
        end else if (round_step) begin
            h <= g;
            g <= f;
            f <= e;
            e <= d + t1;
            d <= c;
            c <= b;
            b <= a;
            a <= t1 + t2;
        end
    end

    always_ff @(posedge clk) begin
        if (running && last_round) begin
            digest[0] <= H_INIT[0] + a;
            digest[1] <= H_INIT[1] + b;
            digest[2] <= H_INIT[2] + c;
            digest[3] <= H_INIT[3] + d;
            digest[4] <= H_INIT[4] + e;
            digest[5] <= H_INIT[5] + f;
            digest[6] <= H_INIT[6] + g;
            digest[7] <= H_INIT[7] + h;
        end
    end

endmodule

`default_nettype wire

// File: sha256_digest_out.sv
`timescale 1ns/1ps
`default_nettype none

module sha256_digest_out
    import sha256_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       digest_done,
    input  digest_t    digest,
    output logic       out_valid,
    output logic [7:0] out_byte,
    output logic       out_active
);

    logic [255:0] dflat;
    logic [255:0] shreg;
    logic [4:0] byte_cnt;

    assign dflat = digest;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_byte  <= '0;
            byte_cnt  <= '0;
        end else if (digest_done) begin
            // First byte goes out straight from the incoming digest
            out_valid <= 1'b1;
            out_byte  <= dflat[255:248];
            byte_cnt  <= '0;
        end else if (out_valid) begin
            if (byte_cnt == 5'(DIGEST_BYTES - 1)) begin
                out_valid <= 1'b0;
                out_byte  <= '0;
            end else begin
                out_byte <= shreg[255:248];
                byte_cnt <= byte_cnt + 5'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (digest_done) begin
            shreg <= {dflat[247:0], 8'h00};
        end else if (out_valid) begin
            shreg <= {shreg[247:0], 8'h00};
        end
    end

    assign out_active = out_valid;

endmodule

`default_nettype wire

// File: sha256_msg_loader.sv
`timescale 1ns/1ps
`default_nettype none

module sha256_msg_loader
    import sha256_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  msg_byte_t in_byte,
    input  logic      out_active,
    output logic      busy,
    output logic      block_start,
    output block_t    block
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_HASH,
        ST_SEND
    } state_t;

    state_t state;
    logic [5:0] cnt;
    logic [0:MAX_MSG_BYTES-1][7:0] msg_buf;
    logic [0:63][7:0] blk_bytes;
    logic [31:0] bit_len;
    logic ready;
    logic take;
    logic [5:0] idx;

    // Digest stream finished counts as idle so the next byte can land at once
    assign ready = (state == ST_IDLE) || (state == ST_SEND && !out_active);
    assign busy  = !ready;
    assign take  = in_valid && (ready || state == ST_LOAD);
    assign idx   = ready ? 6'd0 : cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            cnt         <= '0;
            block_start <= 1'b0;
        end else begin
            block_start <= 1'b0;
            if (take) begin
                cnt <= idx + 6'd1;
                if (in_byte.last || idx == 6'(MAX_MSG_BYTES - 1)) begin
                    state       <= ST_HASH;
                    block_start <= 1'b1;
                end else begin
                    state <= ST_LOAD;
                end
            end else if (state == ST_HASH && out_active) begin
                state <= ST_SEND;
            end else if (state == ST_SEND && !out_active) begin
                state <= ST_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            msg_buf[idx] <= in_byte.data;
        end
    end

    // Padded block holds the message, 0x80, zeros and the bit length in the low word
    assign bit_len = {23'd0, cnt, 3'b000};

    always_comb begin
        blk_bytes = '0;
        for (int i = 0; i < MAX_MSG_BYTES; i++) begin
            if (i < int'(cnt)) begin
                blk_bytes[i] = msg_buf[i];
            end else if (i == int'(cnt)) begin
                blk_bytes[i] = 8'h80;
            end
        end
        blk_bytes[55] = (cnt == 6'(MAX_MSG_BYTES)) ? 8'h80 : 8'h00;
        blk_bytes[60] = bit_len[31:24];
        blk_bytes[61] = bit_len[23:16];
        blk_bytes[62] = bit_len[15:8];
        blk_bytes[63] = bit_len[7:0];
    end

    assign block = block_t'(blk_bytes);

endmodule

`default_nettype wire

// File: sha256_pkg.sv
`default_nettype none

package sha256_pkg;

    typedef logic [31:0] word_t;
    typedef word_t [0:15] block_t;
    typedef word_t [0:7] digest_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } msg_byte_t;

    localparam int MAX_MSG_BYTES = 55;
    localparam int DIGEST_BYTES = 32;
    localparam int NUM_ROUNDS = 64;

    localparam word_t [0:63] K_TABLE = {
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    localparam digest_t H_INIT = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    function automatic word_t round_k(input logic [5:0] idx);
        return K_TABLE[idx];
    endfunction

    function automatic word_t rotr(input word_t x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic word_t small_sigma0(input word_t x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic word_t small_sigma1(input word_t x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

    function automatic word_t big_sigma0(input word_t x);
        return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
    endfunction

    function automatic word_t big_sigma1(input word_t x);
        return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endfunction

    function automatic word_t ch(input word_t x, input word_t y, input word_t z);
        return (x & y) ^ (~x & z);
    endfunction

    function automatic word_t maj(input word_t x, input word_t y, input word_t z);
        return (x & y) ^ (x & z) ^ (y & z);
    endfunction

endpackage

`default_nettype wire

// File: sha256_schedule.sv
`timescale 1ns/1ps
`default_nettype none

module sha256_schedule
    import sha256_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   block_start,
    input  block_t block,
    input  logic   round_step,
    output word_t  w_cur
);

    word_t window [0:15];
    word_t w_next;

    // W[t] from W[t-2], W[t-7], W[t-15] and W[t-16]
    assign w_next = small_sigma1(window[14]) + window[9]
                  + small_sigma0(window[1]) + window[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                window[i] <= '0;
            end
        end else if (block_start) begin
            for (int i = 0; i < 16; i++) begin
                window[i] <= block[i];
            end
        end else if (round_step) begin
            for (int i = 0; i < 15; i++) begin
                window[i] <= window[i+1];
            end
            window[15] <= w_next;
        end
    end

    assign w_cur = window[0];

endmodule

`default_nettype wire

// File: sha256_top.sv
`timescale 1ns/1ps
`default_nettype none

module sha256_top
    import sha256_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  msg_byte_t  in_byte,
    output logic       busy,
    output logic       out_valid,
    output logic [7:0] out_byte
);

    logic    block_start;
    block_t  block;
    logic    round_step;
    word_t   w_cur;
    logic    digest_done;
    digest_t digest;
    logic    out_active;

    sha256_msg_loader u_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_byte     (in_byte),
        .out_active  (out_active),
        .busy        (busy),
        .block_start (block_start),
        .block       (block)
    );

    sha256_schedule u_schedule (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_start (block_start),
        .block       (block),
        .round_step  (round_step),
        .w_cur       (w_cur)
    );

    sha256_compress u_compress (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_start (block_start),
        .w_cur       (w_cur),
        .round_step  (round_step),
        .digest_done (digest_done),
        .digest      (digest)
    );

    sha256_digest_out u_digest_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .digest_done (digest_done),
        .digest      (digest),
        .out_valid   (out_valid),
        .out_byte    (out_byte),
        .out_active  (out_active)
    );

endmodule

`default_nettype wire

// File: tb_sha256_model.svh
`ifndef TB_SHA256_MODEL_SVH
`define TB_SHA256_MODEL_SVH

// Message under test and the digest the model expects for it
logic [7:0] msg_data [0:63];
logic [7:0] exp_digest [0:DIGEST_BYTES-1];

function automatic logic [31:0] rotate_right(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
endfunction

function automatic logic [31:0] lower_sigma0(input logic [31:0] x);
    return rotate_right(x, 7) ^ rotate_right(x, 18) ^ (x >> 3);
endfunction

function automatic logic [31:0] lower_sigma1(input logic [31:0] x);
    return rotate_right(x, 17) ^ rotate_right(x, 19) ^ (x >> 10);
endfunction

function automatic logic [31:0] upper_sigma0(input logic [31:0] x);
    return rotate_right(x, 2) ^ rotate_right(x, 13) ^ rotate_right(x, 22);
endfunction

function automatic logic [31:0] upper_sigma1(input logic [31:0] x);
    return rotate_right(x, 6) ^ rotate_right(x, 11) ^ rotate_right(x, 25);
endfunction

// One-block SHA-256 of msg_data[0 .. len-1]
task automatic build_expected(input int len);
    logic [7:0] pad [0:63];
    logic [31:0] w [0:63];
    logic [31:0] v [0:7];
    logic [31:0] t1;
    logic [31:0] t2;
    logic [31:0] word;
    logic [63:0] nbits;
    for (int i = 0; i < 64; i++) begin
        pad[i] = (i < len) ? msg_data[i] : 8'h00;
    end
    pad[len] = 8'h80;
    nbits = 64'(len) << 3;
    for (int i = 0; i < 8; i++) begin
        pad[56 + i] = nbits[63 - 8*i -: 8];
    end
    for (int t = 0; t < 16; t++) begin
        w[t] = {pad[4*t], pad[4*t + 1], pad[4*t + 2], pad[4*t + 3]};
    end
    for (int t = 16; t < 64; t++) begin
        w[t] = lower_sigma1(w[t-2]) + w[t-7] + lower_sigma0(w[t-15]) + w[t-16];
    end
    for (int i = 0; i < 8; i++) begin
        v[i] = H_INIT[i];
    end
    for (int t = 0; t < 64; t++) begin
        t1 = v[7] + upper_sigma1(v[4]) + ((v[4] & v[5]) ^ (~v[4] & v[6])) + K_TABLE[t] + w[t];
        t2 = upper_sigma0(v[0]) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
        for (int i = 7; i > 0; i--) begin
            v[i] = v[i-1];
        end
        // v[4] holds the old d after the shift
        v[4] = v[4] + t1;
        v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) begin
        word = v[i] + H_INIT[i];
        for (int j = 0; j < 4; j++) begin
            exp_digest[4*i + j] = word[31 - 8*j -: 8];
        end
    end
endtask

`endif

// File: tb_sha256.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sha256
    import sha256_pkg::*;
();

    // Eleven messages of at most about 160 cycles each with margin on top
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int WAIT_LIMIT = NUM_ROUNDS + 16;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    msg_byte_t  in_byte;
    logic       busy;
    logic       out_valid;
    logic [7:0] out_byte;

    integer seed = 32'h2e3abbbb;
    int errors = 0;
    int checks = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_count = 0;

    `include "tb_sha256_model.svh"

    sha256_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_byte   (in_byte),
        .busy      (busy),
        .out_valid (out_valid),
        .out_byte  (out_byte)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic fill_random(input int len);
        for (int i = 0; i < len; i++) begin
            msg_data[i] = 8'($random(seed));
        end
    endtask

    // Drives one byte per cycle starting at the current falling edge
    task automatic send_message(input int len);
        for (int i = 0; i < len; i++) begin
            in_valid = 1'b1;
            in_byte.data = msg_data[i];
            in_byte.last = (i == len - 1);
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_byte = '0;
    endtask

    task automatic collect_digest();
        int waited;
        waited = 0;
        while (!out_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            $display("ERROR at %0t: out_valid never rose after the message", $time);
            errors++;
            return;
        end
        for (int k = 0; k < DIGEST_BYTES; k++) begin
            checks += 2;
            if (out_valid !== 1'b1) begin
                $display("FAILED at %0t: out_valid got %b expected 1", $time, out_valid);
                errors++;
            end
            if (out_byte !== exp_digest[k]) begin
                $display("FAILED at %0t: out_byte[%0d] got %02h expected %02h",
                         $time, k, out_byte, exp_digest[k]);
                errors++;
            end
            @(negedge clk);
        end
        // Stream must end after exactly 32 bytes and free the input
        checks += 2;
        if (out_valid !== 1'b0) begin
            $display("FAILED at %0t: out_valid got %b expected 0", $time, out_valid);
            errors++;
        end
        if (busy !== 1'b0) begin
            $display("FAILED at %0t: busy got %b expected 0", $time, busy);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic hash_known_abc();
        int start_errors;
        logic [255:0] known;
        start_errors = errors;
        known = 256'hba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad;
        checks += 3;
        if (busy !== 1'b0) begin
            $display("FAILED at %0t: busy got %b expected 0", $time, busy);
            errors++;
        end
        if (out_valid !== 1'b0) begin
            $display("FAILED at %0t: out_valid got %b expected 0", $time, out_valid);
            errors++;
        end
        if (out_byte !== 8'h00) begin
            $display("FAILED at %0t: out_byte got %02h expected 00", $time, out_byte);
            errors++;
        end
        msg_data[0] = 8'h61;
        msg_data[1] = 8'h62;
        msg_data[2] = 8'h63;
        for (int k = 0; k < DIGEST_BYTES; k++) begin
            exp_digest[k] = known[255 - 8*k -: 8];
        end
        send_message(3);
        collect_digest();
        report_test("known_digest", start_errors);
    endtask

    task automatic hash_longest_message();
        int start_errors;
        start_errors = errors;
        fill_random(MAX_MSG_BYTES);
        build_expected(MAX_MSG_BYTES);
        send_message(MAX_MSG_BYTES);
        collect_digest();
        report_test("longest_message", start_errors);
    endtask

    task automatic drop_overflow_bytes();
        int start_errors;
        start_errors = errors;
        fill_random(60);
        build_expected(MAX_MSG_BYTES);
        send_message(60);
        collect_digest();
        report_test("overflow", start_errors);
    endtask

    task automatic ignore_strobes_while_busy();
        int start_errors;
        logic [31:0] r;
        start_errors = errors;
        fill_random(20);
        build_expected(20);
        send_message(20);
        for (int n = 0; n < 20; n++) begin
            checks++;
            if (busy !== 1'b1) begin
                $display("FAILED at %0t: busy got %b expected 1", $time, busy);
                errors++;
            end
            r = $random(seed);
            in_valid = r[0];
            in_byte.data = r[15:8];
            in_byte.last = r[1];
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_byte = '0;
        collect_digest();
        report_test("strobes_while_busy", start_errors);
    endtask

    task automatic run_back_to_back();
        int start_errors;
        start_errors = errors;
        fill_random(10);
        build_expected(10);
        send_message(10);
        collect_digest();
        // Second message starts on the cycle after out_valid falls
        fill_random(33);
        build_expected(33);
        send_message(33);
        collect_digest();
        report_test("back_to_back", start_errors);
    endtask

    task automatic hash_random_messages();
        int start_errors;
        int len;
        logic [31:0] r;
        start_errors = errors;
        for (int m = 0; m < 5; m++) begin
            r = $random(seed);
            len = 1 + int'(r[15:0]) % MAX_MSG_BYTES;
            fill_random(len);
            build_expected(len);
            send_message(len);
            collect_digest();
        end
        report_test("random_messages", start_errors);
    endtask

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_byte = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        hash_known_abc();
        hash_longest_message();
        drop_overflow_bytes();
        ignore_strobes_while_busy();
        run_back_to_back();
        hash_random_messages();
        $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
